// ==== dv/lsu_subsys_tb.sv ====
`timescale 1ns/1ps

module lsu_subsys_tb;

    localparam int MAX_OPS   = 400;
    localparam int OP_CYCLES = int'(riscv_pkg::RAM_GNT_WAIT)
                             + int'(riscv_pkg::RAM_RVALID_WAIT) + 4;
    localparam int TIMEOUT_CYCLES = MAX_OPS * OP_CYCLES + 50;

    logic                       CLK;
    logic                       RSTn;
    logic                       mem_req;
    logic                       mem_we;
    riscv_pkg::mem_size_e       mem_size;
    logic                       mem_unsigned;
    logic [riscv_pkg::XLEN-1:0] mem_addr;
    logic [riscv_pkg::XLEN-1:0] mem_wdata;
    logic                       busy;
    logic [riscv_pkg::XLEN-1:0] mem_rdata;

    logic [31:0] model_mem [256]; // Reference copy of the data RAM
    logic [31:0] last_rdata;      // Last load result the core should see
    int          errors;
    int          checks;
    int          cycle_cnt;

    lsu_subsys dut_i (
        .CLK          (CLK),
        .RSTn         (RSTn),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .busy         (busy),
        .mem_rdata    (mem_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    // Word index from address bits 9:2
    function automatic logic [31:0] model_load(logic [31:0] addr, riscv_pkg::mem_size_e sz,
                                               logic uns);
        logic [31:0] w;
        logic [7:0]  b;
        logic [15:0] h;
        w = model_mem[addr[9:2]];
        b = w[8*int'(addr[1:0]) +: 8];
        h = w[16*int'(addr[1]) +: 16];
        case (sz)
            riscv_pkg::BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
            riscv_pkg::HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
            default:         return w;
        endcase
    endfunction

    function automatic void model_store(logic [31:0] addr, riscv_pkg::mem_size_e sz,
                                        logic [31:0] data);
        case (sz)
            riscv_pkg::BYTE: model_mem[addr[9:2]][8*int'(addr[1:0]) +: 8] = data[7:0];
            riscv_pkg::HALF: model_mem[addr[9:2]][16*int'(addr[1]) +: 16] = data[15:0];
            default:         model_mem[addr[9:2]] = data;
        endcase
    endfunction

    function automatic logic [31:0] rand_addr(riscv_pkg::mem_size_e sz);
        logic [31:0] a;
        a = $urandom; // Upper bits stay random since the RAM ignores them
        case (sz)
            riscv_pkg::HALF: a[0] = 1'b0;
            riscv_pkg::WORD: a[1:0] = 2'b00;
            default: ;
        endcase
        return a;
    endfunction

    // Starts and ends on a falling edge
    task automatic do_op(input string name, input logic we, input riscv_pkg::mem_size_e sz,
                         input logic uns, input logic [31:0] addr, input logic [31:0] wdata);
        logic [31:0] exp;
        exp = we ? last_rdata : model_load(addr, sz, uns);
        mem_req      = 1'b1;
        mem_we       = we;
        mem_size     = sz;
        mem_unsigned = uns;
        mem_addr     = addr;
        mem_wdata    = wdata;
        @(posedge CLK);
        check_val({name, " busy rise"}, 32'd1, 32'(busy));
        @(negedge CLK);
        while (busy === 1'b1) begin
            check_val({name, " rdata hold"}, last_rdata, mem_rdata);
            @(negedge CLK);
        end
        check_val(name, exp, mem_rdata); // Completion cycle
        if (we) begin
            model_store(addr, sz, wdata);
        end else begin
            last_rdata = exp;
        end
        @(posedge CLK);
        @(negedge CLK);
    endtask

    task automatic idle_cycles(input int n);
        mem_req = 1'b0;
        repeat (n) begin
            mem_addr  = $urandom;
            mem_wdata = $urandom;
            @(posedge CLK);
            check_val("idle busy", 32'd0, 32'(busy));
            check_val("idle rdata hold", last_rdata, mem_rdata);
            @(negedge CLK);
        end
    endtask

    initial begin : main
        logic [31:0]          rnd;
        logic [31:0]          addr;
        riscv_pkg::mem_size_e sz;

        rnd          = $urandom(32'hfc39);
        errors       = 0;
        checks       = 0;
        last_rdata   = '0;
        RSTn         = 1'b0;
        mem_req      = 1'b0;
        mem_we       = 1'b0;
        mem_size     = riscv_pkg::WORD;
        mem_unsigned = 1'b0;
        mem_addr     = '0;
        mem_wdata    = '0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = '0;
        end

        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RSTn = 1'b1;
        @(posedge CLK);
        check_val("reset busy", 32'd0, 32'(busy));
        check_val("reset rdata", 32'd0, mem_rdata);
        @(negedge CLK);

        // RAM starts cleared
        for (int i = 0; i < 8; i++) begin
            do_op("reset_load", 1'b0, riscv_pkg::WORD, 1'b0, rand_addr(riscv_pkg::WORD), '0);
        end
        idle_cycles(2);

        for (int i = 0; i < 40; i++) begin
            addr = rand_addr(riscv_pkg::WORD);
            do_op("word_store", 1'b1, riscv_pkg::WORD, 1'b0, addr, $urandom);
            do_op("word_load", 1'b0, riscv_pkg::WORD, 1'b0, addr, '0);
        end

        for (int i = 0; i < 30; i++) begin
            rnd  = $urandom;
            sz   = rnd[0] ? riscv_pkg::HALF : riscv_pkg::BYTE;
            addr = rand_addr(sz);
            do_op("subword_store", 1'b1, sz, 1'b0, addr, $urandom);
            do_op("subword_check", 1'b0, riscv_pkg::WORD, rnd[1], addr & 32'hffff_fffc, '0);
        end

        for (int i = 0; i < 20; i++) begin
            rnd  = $urandom;
            addr = rand_addr(riscv_pkg::WORD);
            do_op("ext_store", 1'b1, riscv_pkg::WORD, 1'b0, addr, $urandom);
            do_op("byte_load", 1'b0, riscv_pkg::BYTE, rnd[0], addr | {30'b0, rnd[2:1]}, '0);
            do_op("half_load", 1'b0, riscv_pkg::HALF, rnd[3], addr | {30'b0, rnd[4], 1'b0}, '0);
            idle_cycles(int'(rnd[6:5]));
        end

        // Back-to-back mix with short gaps
        for (int i = 0; i < 150; i++) begin
            rnd = $urandom;
            case (rnd[5:4])
                2'd0:    sz = riscv_pkg::BYTE;
                2'd1:    sz = riscv_pkg::HALF;
                default: sz = riscv_pkg::WORD;
            endcase
            do_op("random_mix", rnd[0], sz, rnd[1], rand_addr(sz), $urandom);
            if (rnd[3:2] == 2'b00) begin
                idle_cycles(int'(rnd[7:6]) + 1);
            end
        end
        idle_cycles(3);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge CLK);
            cycle_cnt++;
        end
        $display("Run hung: test did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== hw/lsu.sv ====
`timescale 1ns/1ps

module lsu (
    input  logic                       CLK,
    input  logic                       RSTn,

    // Core side
    input  logic                       mem_req,
    input  logic                       mem_we,
    input  riscv_pkg::mem_size_e       mem_size,
    input  logic                       mem_unsigned,
    input  logic [riscv_pkg::XLEN-1:0] mem_addr,
    input  logic [riscv_pkg::XLEN-1:0] mem_wdata,
    output logic                       busy,
    output logic [riscv_pkg::XLEN-1:0] mem_rdata,

    // Data bus
    obi_intf.to_mem                    bus
);

    riscv_pkg::lsu_state_e     state_q;
    riscv_pkg::lsu_state_e     state_d;

    // Access attributes taken at the grant edge
    riscv_pkg::mem_size_e      size_q;
    logic                      unsigned_q;
    logic                      we_q;
    logic [1:0]                addr_lo_q;

    riscv_pkg::mem_size_e      align_size;
    logic [1:0]                align_addr_lo;
    riscv_pkg::lsu_word_u      st_lane;
    logic [3:0]                st_be;
    logic [riscv_pkg::XLEN-1:0] ld_data;
    logic [riscv_pkg::XLEN-1:0] rdata_q;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state_q <= riscv_pkg::WAIT_REQ;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin : fsm
        state_d  = state_q;
        bus.req  = 1'b0;
        busy     = 1'b0;
        case (state_q)
            riscv_pkg::WAIT_REQ: begin
                if (mem_req) begin
                    bus.req = 1'b1;
                    busy    = 1'b1;
                    state_d = bus.gnt ? riscv_pkg::WAIT_VALID : riscv_pkg::WAIT_GNT;
                end
            end
            riscv_pkg::WAIT_GNT: begin
                bus.req = 1'b1;
                busy    = 1'b1;
                if (bus.gnt) begin
                    state_d = riscv_pkg::WAIT_VALID;
                end
            end
            riscv_pkg::WAIT_VALID: begin
                busy = !bus.rvalid; // Drops in the response cycle
                if (bus.rvalid) begin
                    state_d = riscv_pkg::WAIT_REQ;
                end
            end
            default: begin
                state_d = riscv_pkg::WAIT_REQ;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (bus.req && bus.gnt) begin
            size_q     <= mem_size;
            unsigned_q <= mem_unsigned;
            we_q       <= mem_we;
            addr_lo_q  <= mem_addr[1:0];
        end
    end

    // Store path runs before grant, load path only after it
    assign align_size    = (state_q == riscv_pkg::WAIT_VALID) ? size_q : mem_size;
    assign align_addr_lo = (state_q == riscv_pkg::WAIT_VALID) ? addr_lo_q : mem_addr[1:0];

    lsu_align align_i (
        .size        (align_size),
        .unsigned_ld (unsigned_q),
        .addr_lo     (align_addr_lo),
        .st_data     (mem_wdata),
        .be          (st_be),
        .st_lane     (st_lane),
        .ld_word     (bus.rdata),
        .ld_data     (ld_data)
    );

    assign bus.addr  = mem_addr;
    assign bus.we    = mem_we;
    assign bus.be    = st_be;
    assign bus.wdata = st_lane.word;

    // Last load result
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            rdata_q <= '0;
        end else if (bus.rvalid && !we_q) begin
            rdata_q <= ld_data;
        end
    end

    assign mem_rdata = (bus.rvalid && !we_q) ? ld_data : rdata_q;

endmodule

// ==== hw/lsu_align.sv ====
`timescale 1ns/1ps

module lsu_align (
    input  riscv_pkg::mem_size_e       size,
    input  logic                       unsigned_ld,
    input  logic [1:0]                 addr_lo,

    // Store side
    input  logic [riscv_pkg::XLEN-1:0] st_data,
    output logic [3:0]                 be,
    output riscv_pkg::lsu_word_u       st_lane,

    // Load side
    input  riscv_pkg::lsu_word_u       ld_word,
    output logic [riscv_pkg::XLEN-1:0] ld_data
);

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    always_comb begin : store_lanes
        case (size)
            riscv_pkg::BYTE: begin
                st_lane.word = riscv_pkg::XLEN'(st_data[7:0]) << {addr_lo, 3'b000};
                be           = 4'b0001 << addr_lo;
            end
            riscv_pkg::HALF: begin
                // Halfwords sit in lanes 1:0 or 3:2
                st_lane.word = riscv_pkg::XLEN'(st_data[15:0]) << {addr_lo[1], 4'b0000};
                be           = addr_lo[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_lane.word = st_data;
                be           = 4'b1111;
            end
        endcase
    end

    always_comb begin : load_lanes
        ld_byte = ld_word.bytes[addr_lo];
        if (addr_lo[1]) begin
            ld_half = {ld_word.bytes[3], ld_word.bytes[2]};
        end else begin
            ld_half = {ld_word.bytes[1], ld_word.bytes[0]};
        end

        case (size)
            riscv_pkg::BYTE: begin
                if (unsigned_ld) begin
                    ld_data = {{(riscv_pkg::XLEN-8){1'b0}}, ld_byte};
                end else begin
                    ld_data = {{(riscv_pkg::XLEN-8){ld_byte[7]}}, ld_byte};
                end
            end
            riscv_pkg::HALF: begin
                if (unsigned_ld) begin
                    ld_data = {{(riscv_pkg::XLEN-16){1'b0}}, ld_half};
                end else begin
                    ld_data = {{(riscv_pkg::XLEN-16){ld_half[15]}}, ld_half};
                end
            end
            default: begin
                ld_data = ld_word.word;
            end
        endcase
    end

endmodule

// ==== hw/lsu_subsys.sv ====
`timescale 1ns/1ps

module lsu_subsys (
    input  logic                       CLK,
    input  logic                       RSTn,

    input  logic                       mem_req,
    input  logic                       mem_we,
    input  riscv_pkg::mem_size_e       mem_size,
    input  logic                       mem_unsigned,
    input  logic [riscv_pkg::XLEN-1:0] mem_addr,
    input  logic [riscv_pkg::XLEN-1:0] mem_wdata,
    output logic                       busy,
    output logic [riscv_pkg::XLEN-1:0] mem_rdata
);

    // Data bus between the LSU and the RAM
    obi_intf bus_if ();

    lsu lsu_i (
        .CLK          (CLK),
        .RSTn         (RSTn),
        .mem_req      (mem_req),
        .mem_we       (mem_we),
        .mem_size     (mem_size),
        .mem_unsigned (mem_unsigned),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .busy         (busy),
        .mem_rdata    (mem_rdata),
        .bus          (bus_if.to_mem)
    );

    obi_data_ram ram_i (
        .CLK  (CLK),
        .RSTn (RSTn),
        .bus  (bus_if.mem)
    );

endmodule

// ==== hw/obi_data_ram.sv ====
`timescale 1ns/1ps

module obi_data_ram (
    input  logic   CLK,
    input  logic   RSTn,
    obi_intf.mem   bus
);

    // Phase flags, both low when idle
    logic addr_wait;
    logic resp_wait;

    logic                           timer_load;
    logic [riscv_pkg::WAIT_W-1:0]   timer_val;
    logic                           timer_exp;

    riscv_pkg::lsu_word_u           mem [riscv_pkg::RAM_WORDS];
    logic [riscv_pkg::RAM_AW-1:0]   word_idx;
    logic [riscv_pkg::XLEN-1:0]     rdata_q;

    assign word_idx = bus.addr[riscv_pkg::RAM_AW+1:2]; // Upper address bits ignored

    assign bus.gnt    = addr_wait && timer_exp;
    assign bus.rvalid = resp_wait && timer_exp;
    assign bus.rdata  = rdata_q;

    // Grant wait starts on a fresh request, response wait at the grant
    assign timer_load = (!addr_wait && !resp_wait && bus.req) || bus.gnt;
    assign timer_val  = bus.gnt ? riscv_pkg::RAM_RVALID_WAIT : riscv_pkg::RAM_GNT_WAIT;

    obi_wait_timer timer_i (
        .CLK      (CLK),
        .RSTn     (RSTn),
        .load     (timer_load),
        .load_val (timer_val),
        .expired  (timer_exp)
    );

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            addr_wait <= 1'b0;
            resp_wait <= 1'b0;
        end else if (!addr_wait && !resp_wait && bus.req) begin
            addr_wait <= 1'b1;
        end else if (bus.gnt) begin
            addr_wait <= 1'b0;
            resp_wait <= 1'b1;
        end else if (bus.rvalid) begin
            resp_wait <= 1'b0;
        end
    end

    // Byte-lane writes at the grant edge
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            for (int i = 0; i < riscv_pkg::RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (bus.gnt && bus.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.be[b]) begin
                    mem[word_idx].bytes[b] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (bus.gnt && !bus.we) begin
            rdata_q <= mem[word_idx].word; // Held until rvalid
        end
    end

endmodule

// ==== hw/obi_intf.sv ====
`timescale 1ns/1ps

interface obi_intf;

    // Address phase
    logic                       req;
    logic                       gnt;
    logic [riscv_pkg::XLEN-1:0] addr;
    logic                       we;
    logic [3:0]                 be;
    logic [riscv_pkg::XLEN-1:0] wdata;

    // Response phase
    logic                       rvalid;
    logic [riscv_pkg::XLEN-1:0] rdata;

    modport to_mem (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport mem (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

// ==== hw/obi_wait_timer.sv ====
`timescale 1ns/1ps

module obi_wait_timer (
    input  logic                         CLK,
    input  logic                         RSTn,
    input  logic                         load,
    input  logic [riscv_pkg::WAIT_W-1:0] load_val,
    output logic                         expired
);

    logic [riscv_pkg::WAIT_W-1:0] count;

    // Load cycle counts as the first wait cycle
    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            count <= '0;
        end else if (load) begin
            count <= (load_val == '0) ? '0 : load_val - 1'b1;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // Also high in the grant cycle that reloads the count
    assign expired = (count == '0);

endmodule

// ==== hw/riscv_pkg.sv ====
package riscv_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Data RAM geometry
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS); // Word index bits, from addr[2] up

    // Wait timer width, must hold the larger of the two waits
    localparam int WAIT_W = 2;

    // RAM wait states, the request cycle counts as the first grant wait
    localparam logic [WAIT_W-1:0] RAM_GNT_WAIT    = 2'd2;
    localparam logic [WAIT_W-1:0] RAM_RVALID_WAIT = 2'd1;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    typedef enum logic [1:0] {
        WAIT_REQ   = 2'b00,
        WAIT_GNT   = 2'b01,
        WAIT_VALID = 2'b10
    } lsu_state_e;

    // One bus word, seen whole or as byte lanes
    typedef union packed {
        logic [XLEN-1:0]      word;
        logic [3:0][7:0]      bytes; // bytes[0] is the lane at addr_lo == 0
    } lsu_word_u;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f vlog.f --top-module lsu_subsys_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vlsu_subsys_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// ==== vlog.f ====
hw/riscv_pkg.sv
hw/obi_intf.sv
hw/obi_wait_timer.sv
hw/lsu_align.sv
hw/lsu.sv
hw/obi_data_ram.sv
hw/lsu_subsys.sv
dv/lsu_subsys_tb.sv
